// File: all.f
+incdir+rtl
rtl/scara_pkg.sv
rtl/joint_move_if.sv
rtl/fifo_read_fsm.sv
rtl/command_dispatch.sv
rtl/step_pulse_gen.sv
rtl/echo_writer.sv
rtl/scara_link_top.sv
sim/tb_clock_gen.sv
sim/tb_scara_link.sv

// File: rtl/command_dispatch.sv
// Decodes accepted command words and launches both stepper joints on a move command
`timescale 1ns/1ps
`include "scara_config.svh"

module command_dispatch import scara_pkg::*; (
	input  logic             CLOCK_50,
	input  logic             rst_n,
	// Accepted word from the read FSM
	input  cmd_word_u        word,
	input  logic             word_valid,
	// Low while a move is pending or running
	output logic             motion_ready,
	// Joint requests
	joint_move_if.dispatcher j1,
	joint_move_if.dispatcher j2
);

	localparam logic [`SCARA_CMD_W-1:0] CMD_MOVE = `SCARA_CMD_MOVE;

	// Decoded fields of the last accepted word
	cmd_fields_t fields_q;
	// Word arrived last cycle
	logic        loaded_q;
	logic        move_start;

	// ========================================================================
	// Field capture
	// ========================================================================

	always_ff @(posedge CLOCK_50) begin
		if (word_valid) begin
			fields_q <= word.f;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			loaded_q <= 1'b0;
		end else begin
			loaded_q <= word_valid;
		end
	end

	// ========================================================================
	// Joint launch
	// ========================================================================

	// Start both joints the cycle after a move word
	assign move_start = loaded_q && (fields_q.cmd == CMD_MOVE);

	// x drives joint 1
	assign j1.start = move_start;
	assign j1.dir   = fields_q.x[`SCARA_ARG_W-1];
	assign j1.steps = fields_q.x[`SCARA_STEPS_W-1:0];

	// y drives joint 2
	assign j2.start = move_start;
	assign j2.dir   = fields_q.y[`SCARA_ARG_W-1];
	assign j2.steps = fields_q.y[`SCARA_STEPS_W-1:0];

	// Covers the start cycle before the joints drop done
	assign motion_ready = !move_start && j1.done && j2.done;

	// ========================================================================
	// Checks
	// ========================================================================

	// Read FSM must wait out a running move
	a_no_word_while_busy: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		word_valid |-> motion_ready
	) else $error("command word accepted while motion busy");

endmodule

// File: rtl/echo_writer.sv
// Echoes every accepted command word into the FPGA-to-HPS FIFO, waiting while that FIFO is full
`timescale 1ns/1ps
`include "scara_config.svh"

module echo_writer import scara_pkg::*; (
	input  logic                     CLOCK_50,
	input  logic                     rst_n,
	// Accepted word from the read FSM
	input  cmd_word_u                word,
	input  logic                     word_valid,
	// Outbound FIFO
	input  logic                     tx_full,
	output logic [`SCARA_WORD_W-1:0] tx_data,
	output logic                     tx_write,
	// Echo still waiting for room
	output logic                     echo_busy
);

	// One-word holding buffer
	logic [`SCARA_WORD_W-1:0] echo_q;
	logic                     pending_q;

	// Raw view only, no decode here
	always_ff @(posedge CLOCK_50) begin
		if (word_valid) begin
			echo_q <= word.raw;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			pending_q <= 1'b0;
		end else if (word_valid) begin
			pending_q <= 1'b1;
		end else if (tx_write) begin
			pending_q <= 1'b0;
		end
	end

	// Write goes out in the first cycle with room
	assign tx_write  = pending_q && !tx_full;
	assign tx_data   = echo_q;
	// Busy drops together with the write pulse
	assign echo_busy = pending_q && !tx_write;

	// ========================================================================
	// Checks
	// ========================================================================

	a_no_write_when_full: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		tx_write |-> !tx_full
	) else $error("tx_write while outbound FIFO full");

	// Read FSM never overruns the one-word buffer
	a_no_overrun: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		word_valid |-> !pending_q
	) else $error("new word arrived before the previous echo was written");

endmodule

// File: rtl/fifo_read_fsm.sv
// Pulls command words from the HPS-to-FPGA FIFO and hands each one to the dispatcher and echo path
`timescale 1ns/1ps
`include "scara_config.svh"

module fifo_read_fsm import scara_pkg::*; (
	input  logic      CLOCK_50,
	input  logic      rst_n,
	// Inbound FIFO
	input  logic      rx_empty,
	input  cmd_word_u rx_data,
	output logic      rx_read,
	// Back-pressure from both consumers
	input  logic      motion_ready,
	input  logic      echo_busy,
	// Accepted word
	output cmd_word_u word,
	output logic      word_valid
);

	rd_state_e state;
	// Word may leave the read state this cycle
	logic      take;

	// Both consumers must be free before a word is handed on
	assign take = (state == RD_READ) && motion_ready && !echo_busy;

	// ========================================================================
	// Read sequence
	// ========================================================================

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state      <= RD_AWAIT;
			rx_read    <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			// Strobes default low
			rx_read    <= 1'b0;
			word_valid <= 1'b0;
			case (state)
				RD_AWAIT: begin
					// Single read strobe as soon as data shows up
					if (!rx_empty) begin
						rx_read <= 1'b1;
						state   <= RD_DELAY_READ;
					end
				end
				RD_DELAY_READ: begin
					// FIFO needs a cycle to present the word
					state <= RD_READ;
				end
				RD_READ: begin
					// Hold the fetched word until both sides can take it
					if (take) begin
						word_valid <= 1'b1;
						state      <= RD_DELAY_AWAIT;
					end
				end
				RD_DELAY_AWAIT: begin
					state <= RD_AWAIT;
				end
				default: begin
					state <= RD_AWAIT;
				end
			endcase
		end
	end

	// Word register, loaded alongside the valid pulse
	always_ff @(posedge CLOCK_50) begin
		if (take) begin
			word <= rx_data;
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// Read strobe is a single-cycle pulse
	a_read_single: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		rx_read |=> !rx_read
	) else $error("rx_read held high for two cycles");

endmodule

// File: rtl/joint_move_if.sv
// One move request from the dispatcher to a stepper joint, with the joint's done level back
`timescale 1ns/1ps
`include "scara_config.svh"

interface joint_move_if;

	// One-cycle pulse that launches a move
	logic start;
	// Direction, valid with start
	logic dir;
	// Number of step pulses, valid with start
	logic [`SCARA_STEPS_W-1:0] steps;
	// High while the joint is idle
	logic done;

	// Command side
	modport dispatcher (
		output start,
		output dir,
		output steps,
		input  done
	);

	// Stepper side
	modport joint (
		input  start,
		input  dir,
		input  steps,
		output done
	);

endinterface

// File: rtl/scara_config.svh
// Word layout, command codes and step timing shared by the SCARA link RTL; include before use
`ifndef SCARA_CONFIG_SVH
`define SCARA_CONFIG_SVH

// ============================================================================
// FIFO word layout
// ============================================================================

// Width of one FIFO word in either direction
`define SCARA_WORD_W 32
// Command code in the low bits
`define SCARA_CMD_W 4
// x argument above the command, y argument on top
`define SCARA_ARG_W 14
// Step count in the low argument bits
// Top argument bit selects direction
`define SCARA_STEPS_W 13

// ============================================================================
// Command codes and step timing
// ============================================================================

// Only this code starts motion, everything else is just echoed
`define SCARA_CMD_MOVE 1
// Cycles the step output stays high
`define SCARA_STEP_HIGH 4
// Cycles from one step rise to the next
`define SCARA_STEP_PERIOD 10

`endif

// File: rtl/scara_link_top.sv
// SCARA command link top level; connects the HPS FIFO ports and both stepper joints
`timescale 1ns/1ps
`include "scara_config.svh"

module scara_link_top import scara_pkg::*; (
	input  logic                     CLOCK_50,
	input  logic                     rst_n,
	// HPS-to-FPGA FIFO read side
	input  logic [`SCARA_WORD_W-1:0] rx_data,
	input  logic                     rx_empty,
	output logic                     rx_read,
	// FPGA-to-HPS FIFO write side
	output logic [`SCARA_WORD_W-1:0] tx_data,
	output logic                     tx_write,
	input  logic                     tx_full,
	// Stepper driver pins
	output logic                     step1,
	output logic                     dir1,
	output logic                     step2,
	output logic                     dir2
);

	// Accepted word and its strobe
	cmd_word_u word;
	logic      word_valid;
	// Back-pressure into the read FSM
	logic      motion_ready;
	logic      echo_busy;

	// One move link per joint
	joint_move_if j1_if ();
	joint_move_if j2_if ();

	// ========================================================================
	// Command path
	// ========================================================================

	fifo_read_fsm u_read (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.rx_empty     (rx_empty),
		.rx_data      (rx_data),
		.rx_read      (rx_read),
		.motion_ready (motion_ready),
		.echo_busy    (echo_busy),
		.word         (word),
		.word_valid   (word_valid)
	);

	command_dispatch u_dispatch (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.word         (word),
		.word_valid   (word_valid),
		.motion_ready (motion_ready),
		.j1           (j1_if.dispatcher),
		.j2           (j2_if.dispatcher)
	);

	echo_writer u_echo (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.word       (word),
		.word_valid (word_valid),
		.tx_full    (tx_full),
		.tx_data    (tx_data),
		.tx_write   (tx_write),
		.echo_busy  (echo_busy)
	);

	// ========================================================================
	// Stepper joints
	// ========================================================================

	step_pulse_gen joint1 (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.mv       (j1_if.joint),
		.step     (step1),
		.dir      (dir1)
	);

	step_pulse_gen joint2 (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.mv       (j2_if.joint),
		.step     (step2),
		.dir      (dir2)
	);

endmodule

// File: rtl/scara_pkg.sv
// Types for the SCARA command link; import into modules that carry or decode command words
`include "scara_config.svh"

package scara_pkg;

	// ========================================================================
	// Command word
	// ========================================================================

	// Field view of one word
	// Declared MSB first so the command lands in the low bits
	typedef struct packed {
		logic [`SCARA_ARG_W-1:0] y;
		logic [`SCARA_ARG_W-1:0] x;
		logic [`SCARA_CMD_W-1:0] cmd;
	} cmd_fields_t;

	// Same word seen two ways
	// Raw view goes back to the host, field view is decoded
	typedef union packed {
		logic [`SCARA_WORD_W-1:0] raw;
		cmd_fields_t              f;
	} cmd_word_u;

	// ========================================================================
	// Inbound FIFO read sequence
	// ========================================================================

	// Await, delay-read, read, delay-await
	typedef enum logic [1:0] {
		RD_AWAIT,
		RD_DELAY_READ,
		RD_READ,
		RD_DELAY_AWAIT
	} rd_state_e;

endpackage

// File: rtl/step_pulse_gen.sv
// Step and direction pulse generator for one stepper joint, started by a move request
`timescale 1ns/1ps
`include "scara_config.svh"

module step_pulse_gen (
	input  logic        CLOCK_50,
	input  logic        rst_n,
	// Move request and done level
	joint_move_if.joint mv,
	// Driver pins
	output logic        step,
	output logic        dir
);

	localparam int TIMER_W = $clog2(`SCARA_STEP_PERIOD);
	// Last tick of a step period
	localparam logic [TIMER_W-1:0] LAST_TICK = TIMER_W'(`SCARA_STEP_PERIOD - 1);
	// Last tick with the step output high
	localparam logic [TIMER_W-1:0] HIGH_END = TIMER_W'(`SCARA_STEP_HIGH - 1);

	// Steps still to finish, including the current one
	logic [`SCARA_STEPS_W-1:0] steps_left;
	// Position inside the current period
	logic [TIMER_W-1:0]        tick;
	logic                      done_q;
	logic                      step_q;
	logic                      dir_q;
	logic                      last_step;

	assign last_step = (steps_left == `SCARA_STEPS_W'(1));

	// ========================================================================
	// Step counter and period timer
	// ========================================================================

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			done_q     <= 1'b1;
			step_q     <= 1'b0;
			dir_q      <= 1'b0;
			steps_left <= '0;
			tick       <= '0;
		end else if (mv.start) begin
			// Direction latched on every start
			dir_q      <= mv.dir;
			steps_left <= mv.steps;
			tick       <= '0;
			// Zero count leaves the joint idle
			if (mv.steps != '0) begin
				done_q <= 1'b0;
				step_q <= 1'b1;
			end
		end else if (!done_q) begin
			if (tick == LAST_TICK) begin
				// Period over
				tick       <= '0;
				steps_left <= steps_left - 1'b1;
				if (last_step) begin
					done_q <= 1'b1;
				end else begin
					// Next pulse rises right away
					step_q <= 1'b1;
				end
			end else begin
				tick <= tick + 1'b1;
				// End of the high part
				if (tick == HIGH_END) begin
					step_q <= 1'b0;
				end
			end
		end
	end

	assign mv.done = done_q;
	assign step    = step_q;
	assign dir     = dir_q;

	// ========================================================================
	// Checks
	// ========================================================================

	// Dispatcher only starts an idle joint
	a_start_when_idle: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		mv.start |-> mv.done
	) else $error("joint started while a move is still running");

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source; 100 ns clock, reset held low for five cycles
`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLOCK_50,
	output logic rst_n
);

	initial begin
		CLOCK_50 = 1'b0;
		forever #50 CLOCK_50 = ~CLOCK_50;
	end

	// Release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst_n = 1'b1;
	end

endmodule

// File: sim/tb_scara_link.sv
// Testbench for the SCARA command link; models both HPS FIFOs and checks echo and step output
`timescale 1ns/1ps
`include "scara_config.svh"

module tb_scara_link;

	localparam int NUM_WORDS = 20;
	// 20 words at up to 160 step cycles plus echo stalls and margin
	localparam int MAX_CYCLES = 10000;

	// Clock and reset
	logic CLOCK_50;
	logic rst_n;
	// Inbound FIFO read side
	logic                     rx_empty;
	logic                     rx_read;
	logic [`SCARA_WORD_W-1:0] rx_data;
	// Outbound FIFO write side
	logic                     tx_write;
	logic                     tx_full;
	logic [`SCARA_WORD_W-1:0] tx_data;
	// Stepper driver pins
	logic step1;
	logic dir1;
	logic step2;
	logic dir2;
	// Next echo the outbound FIFO should see
	logic [`SCARA_WORD_W-1:0] exp_word;
	// Words still to hand to the DUT
	logic [`SCARA_WORD_W-1:0] rx_q[$];
	// Words still to be echoed, in send order
	logic [`SCARA_WORD_W-1:0] echo_exp[$];
	// Expected moves per joint with direction in bit 16 above the count
	int j1_moves[$];
	int j2_moves[$];
	// Run length and strobe counts
	int cycles = 0;
	int reads  = 0;
	int writes = 0;
	// Per-joint pulse tracking
	int   since_rise[2] = '{1000, 1000};
	int   steps_left[2] = '{0, 0};
	int   high_len[2]   = '{0, 0};
	logic prev_step[2]  = '{1'b0, 1'b0};
	logic move_dir[2];

	tb_clock_gen u_clk (.CLOCK_50(CLOCK_50), .rst_n(rst_n));

	scara_link_top DUT (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .rx_data(rx_data), .rx_empty(rx_empty),
		.rx_read(rx_read), .tx_data(tx_data), .tx_write(tx_write), .tx_full(tx_full),
		.step1(step1), .dir1(dir1), .step2(step2), .dir2(dir2)
	);

	task automatic stop_failed();
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		stop_failed();
	endtask

	task automatic report_mismatch(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Error %s: expected %0h, actual %0h", test, expected, actual);
		stop_failed();
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic build_stimulus();
		logic [31:0] r;
		logic [3:0]  cmd, sx, sy;
		logic [13:0] x, y;
		int          i;
		r = 32'h8fffebed;
		for (i = 0; i < NUM_WORDS; i++) begin
			r = lcg_step(r);
			// Every seventh word is a move with an idle joint 1
			sx = (i % 7 == 3) ? 4'd0 : r[19:16];
			sy = r[23:20];
			if (r[31] || (i % 7 == 3)) begin
				cmd = 4'(`SCARA_CMD_MOVE);
				x   = {r[24], 9'd0, sx};
				y   = {r[25], 9'd0, sy};
				if (sx != 0) j1_moves.push_back((int'(r[24]) << 16) | int'(sx));
				if (sy != 0) j2_moves.push_back((int'(r[25]) << 16) | int'(sy));
			end else begin
				// Any code but the move code
				cmd = r[30:27];
				if (cmd == 4'(`SCARA_CMD_MOVE)) begin
					cmd = 4'hf;
				end
				r   = lcg_step(r);
				x   = r[13:0];
				y   = r[27:14];
			end
			rx_q.push_back({y, x, cmd});
			echo_exp.push_back({y, x, cmd});
		end
	endtask

	// Inbound FIFO model and outbound full stretches
	always @(negedge CLOCK_50) begin
		if (rx_read === 1'b1) begin
			assert (rx_q.size() != 0) else report_failure("rx_read while inbound FIFO empty");
			rx_data = rx_q.pop_front();
		end
		rx_empty = (rx_q.size() == 0);
		// Full for 30 cycles out of every 90
		tx_full = ((cycles / 30) % 3) == 1;
	end

	always @(posedge CLOCK_50) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
			report_failure($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
	end

	// ========================================================================
	// Checkers
	// ========================================================================

	a_reset_quiet: assert property (@(posedge CLOCK_50)
		!rst_n |=> !(rx_read || tx_write || step1 || step2))
		else report_failure("FIFO strobes or step outputs active right after reset");

	a_full_blocks_write: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		tx_full |-> !tx_write)
		else report_failure("tx_write pulsed while outbound FIFO full");

	// Echo order and read lead
	always @(posedge CLOCK_50) begin
		if (rst_n) begin
			if (rx_read) reads = reads + 1;
			if (tx_write) begin
				writes = writes + 1;
				assert (echo_exp.size() != 0) else report_failure("echo with no word outstanding");
				exp_word = echo_exp.pop_front();
				assert (tx_data == exp_word) else report_mismatch("echo order", exp_word, tx_data);
			end
			assert (reads - writes <= 2) else report_mismatch("read lead", 2, reads - writes);
		end
	end

	// Pulse width, spacing, count and direction for one joint
	task automatic check_joint(input int j, input logic s, input logic d);
		int entry;
		since_rise[j] = since_rise[j] + 1;
		if (s && !prev_step[j]) begin
			if (steps_left[j] != 0) begin
				assert (since_rise[j] == `SCARA_STEP_PERIOD) else report_mismatch(
					$sformatf("joint%0d step spacing", j + 1), `SCARA_STEP_PERIOD, since_rise[j]);
			end else begin
				assert (since_rise[j] > `SCARA_STEP_PERIOD)
					else report_failure($sformatf("joint%0d made an extra step pulse", j + 1));
				assert ((j == 0 ? j1_moves.size() : j2_moves.size()) != 0)
					else report_failure($sformatf("joint%0d stepped with no move pending", j + 1));
				entry         = (j == 0) ? j1_moves.pop_front() : j2_moves.pop_front();
				steps_left[j] = entry[15:0];
				move_dir[j]   = entry[16];
			end
			steps_left[j] = steps_left[j] - 1;
			since_rise[j] = 0;
		end
		if (s) begin
			high_len[j] = high_len[j] + 1;
			assert (d == move_dir[j])
				else report_mismatch($sformatf("joint%0d direction", j + 1), move_dir[j], d);
		end else if (prev_step[j]) begin
			assert (high_len[j] == `SCARA_STEP_HIGH) else report_mismatch(
				$sformatf("joint%0d pulse width", j + 1), `SCARA_STEP_HIGH, high_len[j]);
			high_len[j] = 0;
		end
		prev_step[j] = s;
	endtask

	always @(posedge CLOCK_50) begin
		if (rst_n) begin
			check_joint(0, step1, dir1);
			check_joint(1, step2, dir2);
		end
	end

	// ========================================================================
	// Run control
	// ========================================================================

	initial begin
		rx_empty = 1'b1;
		rx_data  = '0;
		tx_full  = 1'b0;
		build_stimulus();
		@(posedge rst_n);
		while (echo_exp.size() != 0) @(negedge CLOCK_50);
		// Longest move plus a quiet stretch for stray pulses
		repeat (16 * `SCARA_STEP_PERIOD + 20) @(negedge CLOCK_50);
		if (j1_moves.size() == 0 && j2_moves.size() == 0 && steps_left[0] == 0 &&
				steps_left[1] == 0 && reads == NUM_WORDS) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_failure("reads or step pulses missing at the end of the run");
		end
	end

endmodule
